// File: all.f
hdl/mem_bus_pkg.sv
hdl/core_port_pkg.sv
hdl/req_holder.sv
hdl/port_arbiter.sv
hdl/word_ram.sv
hdl/mem_interface.sv
sim/tb_mem_interface.sv

// File: Bender.yml
package:
  name: mem_interface

sources:
  - files:
      - hdl/mem_bus_pkg.sv
      - hdl/core_port_pkg.sv
      - hdl/req_holder.sv
      - hdl/port_arbiter.sv
      - hdl/word_ram.sv
      - hdl/mem_interface.sv
  - target: simulation
    files:
      - sim/tb_mem_interface.sv

// File: sim/tb_mem_interface.sv
`timescale 1ns/1ns

module tb_mem_interface;

    import mem_bus_pkg::*;
    import core_port_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int READ_LATENCY = 3;
    localparam int PRELOAD_N    = MEM_WORDS;
    localparam int STROBE_N     = 64;
    localparam int FETCH_N      = 200;
    localparam int CONTEND_CYC  = 2000;
    localparam int BURST_N      = 32;
    localparam int TOTAL_N      = 2 * PRELOAD_N + 2 * STROBE_N + FETCH_N
                                  + 2 * CONTEND_CYC + BURST_N;
    localparam int CYCLE_LIMIT  = 20 * TOTAL_N + 200;

    logic       clk = 1'b0;
    logic       reset;
    logic       fetch_valid;
    fetch_req_t fetch_req;
    logic       fetch_ready;
    logic       fetch_rsp_valid;
    word_t      fetch_rdata;
    logic       data_valid;
    data_req_t  data_req;
    logic       data_ready;
    logic       data_rsp_valid;
    word_t      data_rdata;

    word_t ref_mem [MEM_WORDS];  // what the RAM should hold
    word_t fetch_q [$];          // expected read data, oldest first
    word_t data_q  [$];
    int    fetch_at_q [$];       // cycle each read was taken, -1 under contention
    int    data_at_q  [$];

    int mismatches   = 0;
    int other_errors = 0;
    int cycle_count  = 0;
    int fetch_reads  = 0;
    int fetch_rsps   = 0;
    int data_reads   = 0;
    int data_rsps    = 0;
    int fetch_stalls = 0;
    int data_stalls  = 0;
    logic contending = 1'b0;
    logic quiet      = 1'b0;  // no responses allowed

    mem_interface #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .fetch_valid     (fetch_valid),
        .fetch_req       (fetch_req),
        .fetch_ready     (fetch_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rdata     (fetch_rdata),
        .data_valid      (data_valid),
        .data_req        (data_req),
        .data_ready      (data_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rdata      (data_rdata)
    );

    always #2 clk = ~clk;

    task automatic check(input word_t actual, input word_t expected, input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
            mismatches++;
        end
    endtask

    // an uncontended read returns two cycles plus the RAM latency after its handshake
    task automatic check_latency(input int taken_at, input string msg);
        if (taken_at >= 0) begin
            check(word_t'(cycle_count - taken_at), word_t'(READ_LATENCY + 2), msg);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    function automatic int word_index(input addr_t a);
        return int'(a[2 +: 8]);
    endfunction

    function automatic addr_t lower_addr();
        return addr_t'($urandom_range(0, MEM_WORDS / 2 - 1) * 4);
    endfunction

    function automatic addr_t upper_addr();
        return addr_t'((MEM_WORDS / 2 + $urandom_range(0, MEM_WORDS / 2 - 1)) * 4);
    endfunction

    function automatic data_req_t random_data_req();
        data_req_t r;
        r.write = 1'($urandom_range(0, 1));
        if (r.write) begin
            r.addr = upper_addr();  // stores stay clear of the fetch region
        end else begin
            r.addr = addr_t'($urandom_range(0, MEM_WORDS - 1) * 4);
        end
        r.wdata  = $urandom();
        r.strobe = 4'($urandom_range(1, 15));
        return r;
    endfunction

    // hold the request until the holder takes it; returns at posedge + 1
    task automatic send_data(input logic wr, input addr_t a, input word_t wd, input strobe_t st);
        logic took;
        data_valid      = 1'b1;
        data_req.write  = wr;
        data_req.addr   = a;
        data_req.wdata  = wd;
        data_req.strobe = st;
        do begin
            @(negedge clk);
            took = data_ready;
            @(posedge clk);
            #1;
        end while (!took);
        data_valid = 1'b0;
    endtask

    task automatic send_fetch(input addr_t a);
        logic took;
        fetch_valid    = 1'b1;
        fetch_req.addr = a;
        do begin
            @(negedge clk);
            took = fetch_ready;
            @(posedge clk);
            #1;
        end while (!took);
        fetch_valid = 1'b0;
    endtask

    // both ports busy every cycle, new request only once the old one is taken
    task automatic run_contention(input int cycles);
        logic f_took;
        logic d_took;
        f_took = 1'b1;
        d_took = 1'b1;
        repeat (cycles) begin
            if (f_took) begin
                fetch_valid    = 1'b1;
                fetch_req.addr = lower_addr();
            end
            if (d_took) begin
                data_valid = 1'b1;
                data_req   = random_data_req();
            end
            @(negedge clk);
            f_took = fetch_ready;
            d_took = data_ready;
            @(posedge clk);
            #1;
        end
        fetch_valid = 1'b0;
        data_valid  = 1'b0;
    endtask

    task automatic drain();
        while (fetch_q.size() != 0 || data_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (READ_LATENCY + 2) @(posedge clk);
        #1;
    endtask

    // handshakes and responses are stable mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (fetch_rsp_valid) begin
                fetch_rsps++;
                if (fetch_q.size() == 0) begin
                    $display("error at %0t: fetch response with no read outstanding", $time);
                    other_errors++;
                end else begin
                    check(fetch_rdata, fetch_q.pop_front(), "fetch read data");
                    check_latency(fetch_at_q.pop_front(), "fetch read latency");
                end
            end
            if (data_rsp_valid) begin
                data_rsps++;
                if (data_q.size() == 0) begin
                    $display("error at %0t: data response with no read outstanding", $time);
                    other_errors++;
                end else begin
                    check(data_rdata, data_q.pop_front(), "data read data");
                    check_latency(data_at_q.pop_front(), "data read latency");
                end
            end
            if (fetch_valid && fetch_ready) begin
                fetch_q.push_back(ref_mem[word_index(fetch_req.addr)]);
                fetch_at_q.push_back(contending ? -1 : cycle_count);
                fetch_reads++;
            end
            if (data_valid && data_ready) begin
                if (data_req.write) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (data_req.strobe[lane]) begin
                            ref_mem[word_index(data_req.addr)][lane*8 +: 8] =
                                data_req.wdata[lane*8 +: 8];
                        end
                    end
                end else begin
                    data_q.push_back(ref_mem[word_index(data_req.addr)]);
                    data_at_q.push_back(contending ? -1 : cycle_count);
                    data_reads++;
                end
            end
            if (contending) begin
                if (!fetch_ready) fetch_stalls++;
                if (!data_ready) data_stalls++;
            end
            if (quiet) begin
                check(word_t'(fetch_rsp_valid), 0, "fetch response during write burst");
                check(word_t'(data_rsp_valid), 0, "data response during write burst");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            other_errors++;
            finish_run();
        end
    end

    initial begin
        addr_t a;
        void'($urandom(96));
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        data_valid  = 1'b0;
        data_req    = '0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check(word_t'(fetch_ready), 1, "fetch_ready after reset");
        check(word_t'(data_ready), 1, "data_ready after reset");
        check(word_t'(fetch_rsp_valid), 0, "fetch_rsp_valid after reset");
        check(word_t'(data_rsp_valid), 0, "data_rsp_valid after reset");
        @(posedge clk);
        #1;
        for (int i = 0; i < PRELOAD_N; i++) begin
            send_data(1'b1, addr_t'(i * 4), $urandom(), 4'hf);
        end
        for (int i = 0; i < PRELOAD_N; i++) begin
            send_data(1'b0, addr_t'(i * 4), '0, '0);
        end
        drain();
        for (int i = 0; i < STROBE_N; i++) begin
            a = upper_addr();
            send_data(1'b1, a, $urandom(), 4'($urandom_range(1, 14)));  // partial lanes
            send_data(1'b0, a, '0, '0);
        end
        drain();
        for (int i = 0; i < FETCH_N; i++) begin
            send_fetch(lower_addr());
        end
        drain();
        contending = 1'b1;
        run_contention(CONTEND_CYC);
        contending = 1'b0;
        drain();
        check(word_t'(fetch_stalls != 0), 1, "fetch back-pressure seen");
        check(word_t'(data_stalls != 0), 1, "data back-pressure seen");
        quiet = 1'b1;
        for (int i = 0; i < BURST_N; i++) begin
            send_data(1'b1, upper_addr(), $urandom(), 4'($urandom_range(1, 15)));
        end
        repeat (READ_LATENCY + 4) @(posedge clk);
        quiet = 1'b0;
        check(word_t'(fetch_q.size()), 0, "fetch reads left unanswered");
        check(word_t'(data_q.size()), 0, "data reads left unanswered");
        check(word_t'(fetch_rsps), word_t'(fetch_reads), "fetch responses vs accepted reads");
        check(word_t'(data_rsps), word_t'(data_reads), "data responses vs accepted reads");
        finish_run();
    end

endmodule

// File: hdl/mem_interface.sv
`timescale 1ns/1ns

module mem_interface #(
    parameter int MEM_WORDS    = 1024,
    parameter int READ_LATENCY = 2
) (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       fetch_valid,
    input  core_port_pkg::fetch_req_t  fetch_req,
    output logic                       fetch_ready,
    output logic                       fetch_rsp_valid,
    output mem_bus_pkg::word_t         fetch_rdata,

    input  logic                       data_valid,
    input  core_port_pkg::data_req_t   data_req,
    output logic                       data_ready,
    output logic                       data_rsp_valid,
    output mem_bus_pkg::word_t         data_rdata
);

    import mem_bus_pkg::*;
    import core_port_pkg::*;

    logic       fetch_held_valid;
    fetch_req_t fetch_held;
    logic       fetch_grant;
    logic       data_held_valid;
    data_req_t  data_held;
    logic       data_grant;
    logic       ram_valid;
    bus_req_t   ram_req;
    logic       rsp_valid;
    bus_rsp_t   rsp;

    // depth has to fit the byte address
    if ($clog2(MEM_WORDS) + ADDR_LSB > $bits(addr_t)) begin : g_bad_depth
        $error("MEM_WORDS does not fit the address width");
    end
    if (READ_LATENCY < 1) begin : g_bad_latency
        $error("READ_LATENCY must be at least 1");
    end

    req_holder #(.payload_t(fetch_req_t)) u_fetch_hold (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (fetch_valid),
        .in_payload   (fetch_req),
        .in_ready     (fetch_ready),
        .held_valid   (fetch_held_valid),
        .held_payload (fetch_held),
        .grant        (fetch_grant)
    );

    req_holder #(.payload_t(data_req_t)) u_data_hold (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (data_valid),
        .in_payload   (data_req),
        .in_ready     (data_ready),
        .held_valid   (data_held_valid),
        .held_payload (data_held),
        .grant        (data_grant)
    );

    port_arbiter #(.READ_LATENCY(READ_LATENCY)) u_arb (
        .clk              (clk),
        .reset            (reset),
        .fetch_held_valid (fetch_held_valid),
        .fetch_held       (fetch_held),
        .fetch_grant      (fetch_grant),
        .data_held_valid  (data_held_valid),
        .data_held        (data_held),
        .data_grant       (data_grant),
        .ram_valid        (ram_valid),
        .ram_req          (ram_req),
        .rsp_valid        (rsp_valid),
        .rsp              (rsp),
        .fetch_rsp_valid  (fetch_rsp_valid),
        .fetch_rdata      (fetch_rdata),
        .data_rsp_valid   (data_rsp_valid),
        .data_rdata       (data_rdata)
    );

    word_ram #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_ram (
        .clk       (clk),
        .reset     (reset),
        .req_valid (ram_valid),
        .req       (ram_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// File: hdl/word_ram.sv
`timescale 1ns/1ns

module word_ram #(
    parameter int MEM_WORDS    = 1024,
    parameter int READ_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  req_valid,
    input  mem_bus_pkg::bus_req_t req,

    output logic                  rsp_valid,
    output mem_bus_pkg::bus_rsp_t rsp
);

    import mem_bus_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    word_t             mem [MEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic              rd_valid [READ_LATENCY];
    word_t             rd_data  [READ_LATENCY];

    assign idx = req.addr[ADDR_LSB +: IDX_W];  // word index, byte offset dropped

    // byte-masked write, committed on the presentation edge
    always_ff @(posedge clk) begin
        if (req_valid && req.write) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (req.strobe[lane]) begin
                    mem[idx][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // read path, first stage samples the array
    always_ff @(posedge clk) begin
        rd_data[0] <= mem[idx];
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_data[i] <= rd_data[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < READ_LATENCY; i++) begin
                rd_valid[i] <= 1'b0;
            end
        end else begin
            rd_valid[0] <= req_valid && !req.write;
            for (int i = 1; i < READ_LATENCY; i++) begin
                rd_valid[i] <= rd_valid[i-1];
            end
        end
    end

    assign rsp_valid = rd_valid[READ_LATENCY-1];
    assign rsp.rdata = rd_data[READ_LATENCY-1];

    a_addr_in_range : assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> req.addr < MEM_WORDS * BYTE_LANES
    );

endmodule

// File: hdl/port_arbiter.sv
`timescale 1ns/1ns

module port_arbiter #(
    parameter int READ_LATENCY = 2
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    fetch_held_valid,
    input  core_port_pkg::fetch_req_t fetch_held,
    output logic                    fetch_grant,

    input  logic                    data_held_valid,
    input  core_port_pkg::data_req_t  data_held,
    output logic                    data_grant,

    output logic                    ram_valid,
    output mem_bus_pkg::bus_req_t   ram_req,

    input  logic                    rsp_valid,
    input  mem_bus_pkg::bus_rsp_t   rsp,

    output logic                    fetch_rsp_valid,
    output mem_bus_pkg::word_t      fetch_rdata,
    output logic                    data_rsp_valid,
    output mem_bus_pkg::word_t      data_rdata
);

    import mem_bus_pkg::*;

    port_tag_t last_grant;
    port_tag_t ram_tag;                      // owner of the request now on the bus
    bus_req_t  fetch_as_bus;
    bus_req_t  data_as_bus;
    logic      tag_valid [READ_LATENCY];
    port_tag_t tag_pipe  [READ_LATENCY];
    logic      tag_out_valid;
    port_tag_t tag_out;

    // fetch is always a plain word read
    assign fetch_as_bus.write  = 1'b0;
    assign fetch_as_bus.addr   = fetch_held.addr;
    assign fetch_as_bus.wdata  = '0;
    assign fetch_as_bus.strobe = '0;

    assign data_as_bus.write  = data_held.write;
    assign data_as_bus.addr   = data_held.addr;
    assign data_as_bus.wdata  = data_held.wdata;
    assign data_as_bus.strobe = data_held.strobe;

    // on a tie the port that lost last time goes first
    assign fetch_grant = fetch_held_valid && (!data_held_valid || last_grant == TAG_DATA);
    assign data_grant  = data_held_valid && (!fetch_held_valid || last_grant == TAG_FETCH);

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= TAG_DATA;  // fetch wins the first tie
            ram_valid  <= 1'b0;
        end else begin
            ram_valid <= fetch_grant || data_grant;
            if (fetch_grant) begin
                last_grant <= TAG_FETCH;
            end else if (data_grant) begin
                last_grant <= TAG_DATA;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_grant) begin
            ram_req <= fetch_as_bus;
            ram_tag <= TAG_FETCH;
        end else if (data_grant) begin
            ram_req <= data_as_bus;
            ram_tag <= TAG_DATA;
        end
    end

    // tag shift pipeline, same depth as the RAM read path
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < READ_LATENCY; i++) begin
                tag_valid[i] <= 1'b0;
            end
        end else begin
            tag_valid[0] <= ram_valid && !ram_req.write;  // writes get no response
            for (int i = 1; i < READ_LATENCY; i++) begin
                tag_valid[i] <= tag_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_pipe[0] <= ram_tag;
        for (int i = 1; i < READ_LATENCY; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    assign tag_out_valid = tag_valid[READ_LATENCY-1];
    assign tag_out       = tag_pipe[READ_LATENCY-1];

    // steer read data back, no extra cycle
    assign fetch_rsp_valid = rsp_valid && tag_out_valid && tag_out == TAG_FETCH;
    assign data_rsp_valid  = rsp_valid && tag_out_valid && tag_out == TAG_DATA;
    assign fetch_rdata     = rsp.rdata;
    assign data_rdata      = rsp.rdata;

    a_one_grant : assert property (
        @(posedge clk) disable iff (reset)
        !(fetch_grant && data_grant)
    );

    // RAM latency and tag depth must agree, or data goes to the wrong port
    a_rsp_has_tag : assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid == tag_out_valid
    );

endmodule

// File: hdl/req_holder.sv
`timescale 1ns/1ns

module req_holder #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_ready,

    output logic     held_valid,
    output payload_t held_payload,
    input  logic     grant
);

    // empty, or being drained this cycle
    assign in_ready = !held_valid || grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            held_valid <= in_valid;  // refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held_payload <= in_payload;
        end
    end

    // the arbiter only picks a holder that has something in it
    a_grant_needs_entry : assert property (
        @(posedge clk) disable iff (reset)
        grant |-> held_valid
    );

    // an entry waiting for its grant does not change under the arbiter
    a_entry_stable : assert property (
        @(posedge clk) disable iff (reset)
        held_valid && !grant |=> held_valid && $stable(held_payload)
    );

endmodule

// File: hdl/core_port_pkg.sv
package core_port_pkg;

    // instruction fetch, always a word read
    typedef struct packed {
        mem_bus_pkg::addr_t addr;
    } fetch_req_t;

    // load/store from the core
    typedef struct packed {
        logic                 write;   // 1 = store, 0 = load
        mem_bus_pkg::addr_t   addr;
        mem_bus_pkg::word_t   wdata;
        mem_bus_pkg::strobe_t strobe;  // byte lanes written on a store
    } data_req_t;

endpackage

// File: hdl/mem_bus_pkg.sv
package mem_bus_pkg;

    // bus geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int BYTE_LANES = WORD_W / 8;
    localparam int ADDR_LSB   = $clog2(BYTE_LANES);  // byte offset bits inside a word

    typedef logic [ADDR_W-1:0]     addr_t;    // byte address, low bits ignored
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BYTE_LANES-1:0] strobe_t;  // one enable per byte lane

    // which requester a read belongs to
    typedef enum logic {
        TAG_FETCH = 1'b0,
        TAG_DATA  = 1'b1
    } port_tag_t;

    // request as presented to the RAM
    typedef struct packed {
        logic    write;
        addr_t   addr;
        word_t   wdata;
        strobe_t strobe;
    } bus_req_t;

    // read data; valid travels beside it
    typedef struct packed {
        word_t rdata;
    } bus_rsp_t;

endpackage
